//--- pause_consts.svh
// Frame geometry and timer precision; params must hold a full PFC field of 18 bytes
`ifndef PAUSE_CONSTS_SVH
`define PAUSE_CONSTS_SVH

// Parameter field of a MAC control frame, sized for PFC
`define PAUSE_PARAMS_BYTES 18

// Frame length on the byte stream, FCS not included
`define PAUSE_MIN_FRAME_BYTES 60

// Fraction bits below the quanta in the refresh timers
`define PAUSE_QFB 8

`endif

//--- pause_pkg.sv
// Shared flow-control types; quanta are in units of 512 bit times, eight priority classes
`default_nettype none

package pause_pkg;

    // ------------------------------
    // Addresses and pause times
    // ------------------------------

    typedef logic [47:0] mac_addr_t;

    typedef logic [15:0] quanta_t;

    // ------------------------------
    // Per-class PFC values
    // ------------------------------

    // One bit per priority class
    typedef logic [7:0] prio_vec_t;

    // Indexed by class, class 0 in the low word
    typedef quanta_t [7:0] prio_quanta_t;

endpackage

`default_nettype wire

//--- mcf_if.sv
// One MAC control frame with valid/ready; fields hold stable until the transfer
`timescale 1ns/1ps
`default_nettype none

`include "pause_consts.svh"

interface mcf_if;
    import pause_pkg::*;

    logic                              valid;
    logic                              ready;
    mac_addr_t                         eth_dst;
    mac_addr_t                         eth_src;
    logic [15:0]                       eth_type;
    logic [15:0]                       opcode;
    // Byte i sits in bits 8i+7:8i and goes on the wire in order of i
    logic [8*`PAUSE_PARAMS_BYTES-1:0]  params;

    modport src (
        output valid, eth_dst, eth_src, eth_type, opcode, params,
        input  ready
    );

    modport sink (
        input  valid, eth_dst, eth_src, eth_type, opcode, params,
        output ready
    );

endinterface

`default_nettype wire

//--- pause_ctrl_tx.sv
// PAUSE/PFC transmit request tracking; no back-pressure on the change path, PFC wins ties
`timescale 1ns/1ps
`default_nettype none

`include "pause_consts.svh"

module pause_ctrl_tx #(
    parameter bit PFC_EN = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst,

    mcf_if.src                       mcf,

    input  logic                     tx_lfc_req,
    input  logic                     tx_lfc_resend,
    input  pause_pkg::prio_vec_t     tx_pfc_req,
    input  logic                     tx_pfc_resend,

    input  pause_pkg::mac_addr_t     cfg_lfc_eth_dst,
    input  pause_pkg::mac_addr_t     cfg_lfc_eth_src,
    input  logic [15:0]              cfg_lfc_eth_type,
    input  logic [15:0]              cfg_lfc_opcode,
    input  logic                     cfg_lfc_en,
    input  pause_pkg::quanta_t       cfg_lfc_quanta,
    input  pause_pkg::quanta_t       cfg_lfc_refresh,
    input  pause_pkg::mac_addr_t     cfg_pfc_eth_dst,
    input  pause_pkg::mac_addr_t     cfg_pfc_eth_src,
    input  logic [15:0]              cfg_pfc_eth_type,
    input  logic [15:0]              cfg_pfc_opcode,
    input  logic                     cfg_pfc_en,
    input  pause_pkg::prio_quanta_t  cfg_pfc_quanta,
    input  pause_pkg::prio_quanta_t  cfg_pfc_refresh,
    input  logic [9:0]               cfg_quanta_step,
    input  logic                     cfg_quanta_clk_en,

    output logic                     stat_lfc_pkt,
    output logic                     stat_lfc_xon,
    output logic                     stat_lfc_xoff,
    output logic                     stat_lfc_paused,
    output logic                     stat_pfc_pkt,
    output pause_pkg::prio_vec_t     stat_pfc_xon,
    output pause_pkg::prio_vec_t     stat_pfc_xoff,
    output pause_pkg::prio_vec_t     stat_pfc_paused
);
    import pause_pkg::*;

    localparam int QW    = $bits(quanta_t);
    localparam int TW    = QW + `PAUSE_QFB;
    localparam int NPRIO = $bits(prio_vec_t);
    localparam int PW    = 8 * `PAUSE_PARAMS_BYTES;

    logic             lfc_req_reg, lfc_req_next;
    logic             lfc_act_reg, lfc_act_next;
    logic             lfc_send_reg, lfc_send_next;
    prio_vec_t        pfc_req_reg, pfc_req_next;
    prio_vec_t        pfc_act_reg, pfc_act_next;
    prio_vec_t        pfc_en_reg, pfc_en_next;
    logic             pfc_send_reg, pfc_send_next;
    logic             pfc_sel_reg, pfc_sel_next;
    logic             valid_reg, valid_next;

    logic [TW-1:0]    lfc_timer_reg, lfc_timer_next;
    logic [TW-1:0]    pfc_timer_reg [NPRIO];
    logic [TW-1:0]    pfc_timer_next [NPRIO];

    logic             lfc_pkt_next, lfc_xon_next, lfc_xoff_next, pfc_pkt_next;
    prio_vec_t        pfc_xon_next, pfc_xoff_next;

    logic             pfc_frame;
    logic [PW-1:0]    lfc_params;
    logic [PW-1:0]    pfc_params;

    // Quanta go on the wire high byte first
    function automatic logic [15:0] wire_order(input quanta_t q);
        return {q[7:0], q[15:8]};
    endfunction

    // ------------------------------
    // Frame contents
    // ------------------------------

    always_comb begin
        lfc_params = '0;
        lfc_params[15:0] = lfc_req_reg ? wire_order(cfg_lfc_quanta) : 16'h0000;

        pfc_params = '0;
        pfc_params[15:0] = {pfc_en_reg, 8'h00};
        for (int k = 0; k < NPRIO; k++) begin
            pfc_params[16*(k+1) +: 16] = pfc_req_reg[k] ? wire_order(cfg_pfc_quanta[k]) : 16'h0000;
        end
    end

    assign pfc_frame    = PFC_EN && pfc_sel_reg;
    assign mcf.valid    = valid_reg;
    assign mcf.eth_dst  = pfc_frame ? cfg_pfc_eth_dst : cfg_lfc_eth_dst;
    assign mcf.eth_src  = pfc_frame ? cfg_pfc_eth_src : cfg_lfc_eth_src;
    assign mcf.eth_type = pfc_frame ? cfg_pfc_eth_type : cfg_lfc_eth_type;
    assign mcf.opcode   = pfc_frame ? cfg_pfc_opcode : cfg_lfc_opcode;
    assign mcf.params   = pfc_frame ? pfc_params : lfc_params;

    assign stat_lfc_paused = lfc_req_reg;
    assign stat_pfc_paused = pfc_req_reg;

    // ------------------------------
    // Request tracking and refresh
    // ------------------------------

    always_comb begin
        lfc_req_next   = lfc_req_reg;
        lfc_act_next   = lfc_act_reg;
        lfc_send_next  = lfc_send_reg | tx_lfc_resend;
        pfc_req_next   = pfc_req_reg;
        pfc_act_next   = pfc_act_reg;
        pfc_en_next    = pfc_en_reg;
        pfc_send_next  = pfc_send_reg | tx_pfc_resend;
        pfc_sel_next   = pfc_sel_reg;
        valid_next     = valid_reg && !mcf.ready;
        lfc_timer_next = lfc_timer_reg;
        pfc_timer_next = pfc_timer_reg;

        lfc_pkt_next  = 1'b0;
        lfc_xon_next  = 1'b0;
        lfc_xoff_next = 1'b0;
        pfc_pkt_next  = 1'b0;
        pfc_xon_next  = '0;
        pfc_xoff_next = '0;

        // An expired timer asks for another XOFF while the class stays requested
        if (cfg_quanta_clk_en) begin
            if (lfc_timer_reg > TW'(cfg_quanta_step)) begin
                lfc_timer_next = lfc_timer_reg - TW'(cfg_quanta_step);
            end else begin
                lfc_timer_next = '0;
                lfc_send_next  = lfc_send_next | lfc_req_reg;
            end
            for (int k = 0; k < NPRIO; k++) begin
                if (pfc_timer_reg[k] > TW'(cfg_quanta_step)) begin
                    pfc_timer_next[k] = pfc_timer_reg[k] - TW'(cfg_quanta_step);
                end else begin
                    pfc_timer_next[k] = '0;
                    pfc_send_next     = pfc_send_next | pfc_req_reg[k];
                end
            end
        end

        if (cfg_lfc_en && !valid_reg) begin
            if (lfc_req_reg != tx_lfc_req) begin
                lfc_req_next  = tx_lfc_req;
                lfc_act_next  = lfc_act_reg | tx_lfc_req;
                lfc_send_next = 1'b1;
            end
            if (lfc_send_reg && !(PFC_EN && cfg_pfc_en && pfc_send_reg)) begin
                pfc_sel_next   = 1'b0;
                valid_next     = lfc_act_reg;
                lfc_act_next   = lfc_req_reg;
                lfc_send_next  = 1'b0;
                lfc_timer_next = lfc_req_reg ? {cfg_lfc_refresh, {`PAUSE_QFB{1'b0}}} : '0;
                lfc_pkt_next   = lfc_act_reg;
                lfc_xon_next   = lfc_act_reg && !lfc_req_reg;
                lfc_xoff_next  = lfc_act_reg && lfc_req_reg;
            end
        end

        if (PFC_EN && cfg_pfc_en && !valid_reg) begin
            if (pfc_req_reg != tx_pfc_req) begin
                pfc_req_next  = tx_pfc_req;
                pfc_act_next  = pfc_act_reg | tx_pfc_req;
                pfc_send_next = 1'b1;
            end
            if (pfc_send_reg) begin
                // Released classes stay enabled in this frame so that they get an XON
                pfc_sel_next  = 1'b1;
                valid_next    = pfc_act_reg != '0;
                pfc_en_next   = pfc_act_reg;
                pfc_act_next  = pfc_req_reg;
                pfc_send_next = 1'b0;
                for (int k = 0; k < NPRIO; k++) begin
                    pfc_timer_next[k] = pfc_req_reg[k] ?
                        {cfg_pfc_refresh[k], {`PAUSE_QFB{1'b0}}} : '0;
                end
                pfc_pkt_next  = pfc_act_reg != '0;
                pfc_xon_next  = pfc_act_reg & ~pfc_req_reg;
                pfc_xoff_next = pfc_act_reg & pfc_req_reg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lfc_req_reg   <= 1'b0;
            lfc_act_reg   <= 1'b0;
            lfc_send_reg  <= 1'b0;
            pfc_req_reg   <= '0;
            pfc_act_reg   <= '0;
            pfc_en_reg    <= '0;
            pfc_send_reg  <= 1'b0;
            pfc_sel_reg   <= PFC_EN;
            valid_reg     <= 1'b0;
            lfc_timer_reg <= '0;
            for (int k = 0; k < NPRIO; k++) begin
                pfc_timer_reg[k] <= '0;
            end
            stat_lfc_pkt  <= 1'b0;
            stat_lfc_xon  <= 1'b0;
            stat_lfc_xoff <= 1'b0;
            stat_pfc_pkt  <= 1'b0;
            stat_pfc_xon  <= '0;
            stat_pfc_xoff <= '0;
        end else begin
            lfc_req_reg   <= lfc_req_next;
            lfc_act_reg   <= lfc_act_next;
            lfc_send_reg  <= lfc_send_next;
            pfc_req_reg   <= pfc_req_next;
            pfc_act_reg   <= pfc_act_next;
            pfc_en_reg    <= pfc_en_next;
            pfc_send_reg  <= pfc_send_next;
            pfc_sel_reg   <= pfc_sel_next;
            valid_reg     <= valid_next;
            lfc_timer_reg <= lfc_timer_next;
            pfc_timer_reg <= pfc_timer_next;
            stat_lfc_pkt  <= lfc_pkt_next;
            stat_lfc_xon  <= lfc_xon_next;
            stat_lfc_xoff <= lfc_xoff_next;
            stat_pfc_pkt  <= pfc_pkt_next;
            stat_pfc_xon  <= pfc_xon_next;
            stat_pfc_xoff <= pfc_xoff_next;
        end
    end

endmodule

`default_nettype wire

//--- mcf_frame_tx.sv
// Control frame to byte stream; one frame at a time, 60 bytes without FCS or preamble
`timescale 1ns/1ps
`default_nettype none

`include "pause_consts.svh"

module mcf_frame_tx (
    input  logic        clk,
    input  logic        rst,

    mcf_if.sink         mcf,

    output logic [7:0]  tx_data,
    output logic        tx_valid,
    output logic        tx_last,
    input  logic        tx_ready
);
    import pause_pkg::*;

    localparam int NBYTES   = `PAUSE_MIN_FRAME_BYTES;
    localparam int CW       = $clog2(NBYTES);
    localparam int SRC_OFS  = 6;
    localparam int TYPE_OFS = 12;
    localparam int OPC_OFS  = 14;
    localparam int PAR_OFS  = 16;
    localparam int PAD_OFS  = PAR_OFS + `PAUSE_PARAMS_BYTES;

    logic                              busy_reg;
    logic [CW-1:0]                     cnt_reg;

    mac_addr_t                         dst_reg;
    mac_addr_t                         src_reg;
    logic [15:0]                       type_reg;
    logic [15:0]                       opcode_reg;
    logic [8*`PAUSE_PARAMS_BYTES-1:0]  params_reg;

    assign mcf.ready = !busy_reg;
    assign tx_valid  = busy_reg;
    assign tx_last   = busy_reg && (cnt_reg == CW'(NBYTES - 1));

    // ------------------------------
    // Byte select
    // ------------------------------

    // Header fields go most significant byte first, params in byte order, then padding
    always_comb begin
        tx_data = 8'h00;
        if (cnt_reg < SRC_OFS) begin
            tx_data = dst_reg[8*(SRC_OFS-1-cnt_reg) +: 8];
        end else if (cnt_reg < TYPE_OFS) begin
            tx_data = src_reg[8*(TYPE_OFS-1-cnt_reg) +: 8];
        end else if (cnt_reg < OPC_OFS) begin
            tx_data = type_reg[8*(OPC_OFS-1-cnt_reg) +: 8];
        end else if (cnt_reg < PAR_OFS) begin
            tx_data = opcode_reg[8*(PAR_OFS-1-cnt_reg) +: 8];
        end else if (cnt_reg < PAD_OFS) begin
            tx_data = params_reg[8*(cnt_reg-PAR_OFS) +: 8];
        end
    end

    // ------------------------------
    // Sequencing
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_reg <= 1'b0;
            cnt_reg  <= '0;
        end else if (!busy_reg) begin
            if (mcf.valid) begin
                busy_reg <= 1'b1;
                cnt_reg  <= '0;
            end
        end else if (tx_ready) begin
            // Step only when a byte moves
            if (tx_last) begin
                busy_reg <= 1'b0;
                cnt_reg  <= '0;
            end else begin
                cnt_reg <= cnt_reg + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mcf.valid && mcf.ready) begin
            dst_reg    <= mcf.eth_dst;
            src_reg    <= mcf.eth_src;
            type_reg   <= mcf.eth_type;
            opcode_reg <= mcf.opcode;
            params_reg <= mcf.params;
        end
    end

endmodule

`default_nettype wire

//--- pause_tx_top.sv
// Flow-control transmit top; the byte stream carries no FCS and is not arbitrated with data
`timescale 1ns/1ps
`default_nettype none

module pause_tx_top #(
    parameter bit PFC_EN = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     tx_lfc_req,
    input  logic                     tx_lfc_resend,
    input  pause_pkg::prio_vec_t     tx_pfc_req,
    input  logic                     tx_pfc_resend,

    input  pause_pkg::mac_addr_t     cfg_lfc_eth_dst,
    input  pause_pkg::mac_addr_t     cfg_lfc_eth_src,
    input  logic [15:0]              cfg_lfc_eth_type,
    input  logic [15:0]              cfg_lfc_opcode,
    input  logic                     cfg_lfc_en,
    input  pause_pkg::quanta_t       cfg_lfc_quanta,
    input  pause_pkg::quanta_t       cfg_lfc_refresh,
    input  pause_pkg::mac_addr_t     cfg_pfc_eth_dst,
    input  pause_pkg::mac_addr_t     cfg_pfc_eth_src,
    input  logic [15:0]              cfg_pfc_eth_type,
    input  logic [15:0]              cfg_pfc_opcode,
    input  logic                     cfg_pfc_en,
    input  pause_pkg::prio_quanta_t  cfg_pfc_quanta,
    input  pause_pkg::prio_quanta_t  cfg_pfc_refresh,
    input  logic [9:0]               cfg_quanta_step,
    input  logic                     cfg_quanta_clk_en,

    output logic                     stat_lfc_pkt,
    output logic                     stat_lfc_xon,
    output logic                     stat_lfc_xoff,
    output logic                     stat_lfc_paused,
    output logic                     stat_pfc_pkt,
    output pause_pkg::prio_vec_t     stat_pfc_xon,
    output pause_pkg::prio_vec_t     stat_pfc_xoff,
    output pause_pkg::prio_vec_t     stat_pfc_paused,

    output logic [7:0]               tx_data,
    output logic                     tx_valid,
    output logic                     tx_last,
    input  logic                     tx_ready
);

    // Control frame from the request tracker to the serializer
    mcf_if mcf ();

    pause_ctrl_tx #(
        .PFC_EN (PFC_EN)
    ) i_ctrl (
        .mcf (mcf),
        .*
    );

    mcf_frame_tx i_frame (
        .clk      (clk),
        .rst      (rst),
        .mcf      (mcf),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_last  (tx_last),
        .tx_ready (tx_ready)
    );

endmodule

`default_nettype wire

//--- tb_pause_tx.sv
// Runs pause_tx_top with PFC_EN=1; tx_ready is random but high three cycles in four
`timescale 1ns/1ps
`default_nettype none

`include "pause_consts.svh"

module tb_pause_tx;
    import pause_pkg::*;

    localparam int NBYTES = `PAUSE_MIN_FRAME_BYTES;

    logic          clk, rst;
    logic          tx_lfc_req, tx_lfc_resend, tx_pfc_resend;
    prio_vec_t     tx_pfc_req;
    mac_addr_t     cfg_lfc_eth_dst, cfg_lfc_eth_src, cfg_pfc_eth_dst, cfg_pfc_eth_src;
    logic [15:0]   cfg_lfc_eth_type, cfg_lfc_opcode, cfg_pfc_eth_type, cfg_pfc_opcode;
    logic          cfg_lfc_en, cfg_pfc_en, cfg_quanta_clk_en;
    quanta_t       cfg_lfc_quanta, cfg_lfc_refresh;
    prio_quanta_t  cfg_pfc_quanta, cfg_pfc_refresh;
    logic [9:0]    cfg_quanta_step;
    logic          stat_lfc_pkt, stat_lfc_xon, stat_lfc_xoff, stat_lfc_paused, stat_pfc_pkt;
    prio_vec_t     stat_pfc_xon, stat_pfc_xoff, stat_pfc_paused;
    logic [7:0]    tx_data;
    logic          tx_valid, tx_last, tx_ready;

    logic [7:0]    cur_frame [NBYTES];
    logic [7:0]    last_frame [NBYTES];
    logic [7:0]    exp_frame [NBYTES];
    int            byte_idx, frame_cnt;
    int            lfc_xoff_cnt, lfc_xon_cnt, pfc_xoff_cnt, pfc_xon_cnt;
    int            lfc_pkt_cnt, pfc_pkt_cnt;
    prio_vec_t     pfc_xoff_seen, pfc_xon_seen;
    logic          hold_pending, held_last;
    logic [7:0]    held_data;
    logic [31:0]   lcg_state;

    pause_tx_top #(.PFC_EN(1'b1)) i_dut (.*);

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first failed check");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] want);
        assert (got == want) else
            stop_run($sformatf("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want));
    endtask

    task automatic wait_frames(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (frame_cnt < target && n < limit) begin
            next_cycle();
            n++;
        end
        if (frame_cnt < target)
            stop_run($sformatf("timeout after %0d cycles waiting for the %s", limit, what));
    endtask

    // Idle means no byte offered for a run of cycles, so nothing is left pending
    task automatic wait_quiet(input int quiet, input int limit, input string what);
        int idle, n;
        idle = 0;
        n = 0;
        while (idle < quiet && n < limit) begin
            next_cycle();
            n++;
            idle = tx_valid ? 0 : idle + 1;
        end
        if (idle < quiet)
            stop_run($sformatf("byte stream never went idle after the %s", what));
    endtask

    // ------------------------------
    // Expected frames
    // ------------------------------

    task automatic set_header(input mac_addr_t dst, input mac_addr_t src,
                              input logic [15:0] typ, input logic [15:0] opc);
        for (int k = 0; k < NBYTES; k++) begin
            exp_frame[k] = 8'h00;
        end
        for (int k = 0; k < 6; k++) begin
            exp_frame[k]     = dst[47-8*k -: 8];
            exp_frame[6 + k] = src[47-8*k -: 8];
        end
        exp_frame[12] = typ[15:8];
        exp_frame[13] = typ[7:0];
        exp_frame[14] = opc[15:8];
        exp_frame[15] = opc[7:0];
    endtask

    // pos counts params bytes
    task automatic put_quanta(input int pos, input quanta_t q);
        exp_frame[16 + pos] = q[15:8];
        exp_frame[17 + pos] = q[7:0];
    endtask

    task automatic check_frame(input string what);
        for (int k = 0; k < NBYTES; k++) begin
            assert (last_frame[k] == exp_frame[k]) else
                stop_run($sformatf("mismatch at %0t: %s byte %0d is %02h, expected %02h",
                                   $time, what, k, last_frame[k], exp_frame[k]));
        end
    endtask

    // ------------------------------
    // Clock, back-pressure, capture
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        tx_ready  = 1'b0;
        lcg_state = 32'h313d;
        forever begin
            @(posedge clk);
            #1;
            lcg_state = lcg_next(lcg_state);
            tx_ready  = lcg_state[17:16] != 2'b00;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            byte_idx      = 0;
            frame_cnt     = 0;
            lfc_xoff_cnt  = 0;
            lfc_xon_cnt   = 0;
            pfc_xoff_cnt  = 0;
            pfc_xon_cnt   = 0;
            lfc_pkt_cnt   = 0;
            pfc_pkt_cnt   = 0;
            pfc_xoff_seen = '0;
            pfc_xon_seen  = '0;
            hold_pending  = 1'b0;
        end else begin
            if (hold_pending) begin
                assert (tx_valid && tx_data == held_data && tx_last == held_last) else
                    stop_run($sformatf("mismatch at %0t: byte %0d changed while stalled",
                                       $time, byte_idx));
            end
            hold_pending = tx_valid && !tx_ready;
            held_data    = tx_data;
            held_last    = tx_last;
            if (tx_valid && tx_ready) begin
                assert (tx_last == (byte_idx == NBYTES - 1)) else
                    stop_run($sformatf("mismatch at %0t: tx_last is %0b on byte %0d",
                                       $time, tx_last, byte_idx));
                cur_frame[byte_idx] = tx_data;
                byte_idx++;
                if (tx_last) begin
                    last_frame = cur_frame;
                    frame_cnt++;
                    byte_idx = 0;
                end
            end
            if (stat_lfc_xoff) lfc_xoff_cnt++;
            if (stat_lfc_xon) lfc_xon_cnt++;
            if (stat_lfc_pkt) begin
                lfc_pkt_cnt++;
            end
            if (stat_pfc_pkt) begin
                pfc_pkt_cnt++;
            end
            if (stat_pfc_xoff != '0) begin
                pfc_xoff_cnt++;
                pfc_xoff_seen = stat_pfc_xoff;
            end
            if (stat_pfc_xon != '0) begin
                pfc_xon_cnt++;
                pfc_xon_seen = stat_pfc_xon;
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        int base, bound;
        prio_vec_t classes;
        rst               = 1'b1;
        tx_lfc_req        = 1'b0;
        tx_lfc_resend     = 1'b0;
        tx_pfc_req        = '0;
        tx_pfc_resend     = 1'b0;
        cfg_lfc_eth_dst   = 48'h0180_c200_0001;
        cfg_lfc_eth_src   = 48'h0200_0000_1234;
        cfg_lfc_eth_type  = 16'h8808;
        cfg_lfc_opcode    = 16'h0001;
        cfg_lfc_en        = 1'b0;
        cfg_lfc_quanta    = 16'h1234;
        cfg_lfc_refresh   = 16'd4;
        cfg_pfc_eth_dst   = 48'h0180_c200_0001;
        cfg_pfc_eth_src   = 48'h0200_0000_5678;
        cfg_pfc_eth_type  = 16'h8808;
        cfg_pfc_opcode    = 16'h0101;
        cfg_pfc_en        = 1'b0;
        cfg_quanta_step   = 10'd256;
        cfg_quanta_clk_en = 1'b0;
        for (int k = 0; k < 8; k++) begin
            cfg_pfc_quanta[k]  = 16'(32'h4010 + 32'h0101 * k);
            cfg_pfc_refresh[k] = 16'h0100;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // Both enables low, so toggling requests must not produce anything
        for (int c = 0; c < 50; c++) begin
            next_cycle();
            expect_eq("tx_valid with flow control off", 32'(tx_valid), 0);
            expect_eq("status with flow control off",
                      32'({stat_lfc_pkt, stat_lfc_xon, stat_lfc_xoff, stat_lfc_paused,
                           stat_pfc_pkt, stat_pfc_xon, stat_pfc_xoff, stat_pfc_paused}), 0);
            tx_lfc_req = c[1];
            tx_pfc_req = 8'(c * 37);
        end
        tx_lfc_req = 1'b0;
        tx_pfc_req = '0;
        next_cycle();
        cfg_lfc_en = 1'b1;
        next_cycle();

        // PAUSE XOFF
        set_header(cfg_lfc_eth_dst, cfg_lfc_eth_src, cfg_lfc_eth_type, cfg_lfc_opcode);
        put_quanta(0, cfg_lfc_quanta);
        base = frame_cnt;
        tx_lfc_req = 1'b1;
        wait_frames(base + 1, 5 * NBYTES + 8, "PAUSE XOFF frame");
        wait_quiet(16, 20 * NBYTES, "PAUSE XOFF frame");
        check_frame("PAUSE XOFF");
        expect_eq("PAUSE XOFF frame count", frame_cnt, base + 1);
        expect_eq("stat_lfc_xoff cycles", lfc_xoff_cnt, 1);
        expect_eq("stat_lfc_pkt cycles after XOFF", lfc_pkt_cnt, frame_cnt);
        expect_eq("stat_lfc_paused after XOFF", 32'(stat_lfc_paused), 1);

        // Refresh timer expires after refresh << QFB / step quanta clocks
        base  = frame_cnt;
        bound = (int'(cfg_lfc_refresh) << `PAUSE_QFB) / int'(cfg_quanta_step) + 5 * NBYTES + 8;
        cfg_quanta_clk_en = 1'b1;
        wait_frames(base + 1, bound, "PAUSE refresh frame");
        check_frame("PAUSE refresh");
        expect_eq("stat_lfc_xoff seen again", 32'(lfc_xoff_cnt >= 2), 1);
        cfg_quanta_clk_en = 1'b0;
        wait_quiet(16, 20 * NBYTES, "refresh frames");
        expect_eq("stat_lfc_pkt cycles after refresh", lfc_pkt_cnt, frame_cnt);

        // PAUSE XON
        set_header(cfg_lfc_eth_dst, cfg_lfc_eth_src, cfg_lfc_eth_type, cfg_lfc_opcode);
        base = frame_cnt;
        tx_lfc_req = 1'b0;
        wait_frames(base + 1, 5 * NBYTES + 8, "PAUSE XON frame");
        wait_quiet(16, 20 * NBYTES, "PAUSE XON frame");
        check_frame("PAUSE XON");
        expect_eq("PAUSE XON frame count", frame_cnt, base + 1);
        expect_eq("stat_lfc_xon cycles", lfc_xon_cnt, 1);
        expect_eq("stat_lfc_pkt cycles after XON", lfc_pkt_cnt, frame_cnt);
        expect_eq("stat_lfc_paused after XON", 32'(stat_lfc_paused), 0);

        // PFC XOFF for classes 2 and 5
        cfg_pfc_en = 1'b1;
        next_cycle();
        classes = 8'h24;
        set_header(cfg_pfc_eth_dst, cfg_pfc_eth_src, cfg_pfc_eth_type, cfg_pfc_opcode);
        exp_frame[17] = classes;
        put_quanta(2 + 2 * 2, cfg_pfc_quanta[2]);
        put_quanta(2 + 2 * 5, cfg_pfc_quanta[5]);
        base = frame_cnt;
        tx_pfc_req = classes;
        wait_frames(base + 1, 5 * NBYTES + 8, "PFC XOFF frame");
        wait_quiet(16, 20 * NBYTES, "PFC XOFF frame");
        check_frame("PFC XOFF");
        expect_eq("PFC XOFF frame count", frame_cnt, base + 1);
        expect_eq("stat_pfc_xoff cycles", pfc_xoff_cnt, 1);
        expect_eq("stat_pfc_pkt cycles after XOFF", pfc_pkt_cnt, 1);
        expect_eq("stat_pfc_xoff classes", 32'(pfc_xoff_seen), 32'(classes));
        expect_eq("stat_pfc_paused after XOFF", 32'(stat_pfc_paused), 32'(classes));

        // Released classes stay enabled with zero quanta
        set_header(cfg_pfc_eth_dst, cfg_pfc_eth_src, cfg_pfc_eth_type, cfg_pfc_opcode);
        exp_frame[17] = classes;
        base = frame_cnt;
        tx_pfc_req = '0;
        wait_frames(base + 1, 5 * NBYTES + 8, "PFC XON frame");
        wait_quiet(16, 20 * NBYTES, "PFC XON frame");
        check_frame("PFC XON");
        expect_eq("PFC XON frame count", frame_cnt, base + 1);
        expect_eq("stat_pfc_xon cycles", pfc_xon_cnt, 1);
        expect_eq("stat_pfc_pkt cycles after XON", pfc_pkt_cnt, 2);
        expect_eq("stat_pfc_xon classes", 32'(pfc_xon_seen), 32'(classes));
        expect_eq("stat_pfc_paused after XON", 32'(stat_pfc_paused), 0);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
pause_pkg.sv
mcf_if.sv
pause_ctrl_tx.sv
mcf_frame_tx.sv
pause_tx_top.sv
tb_pause_tx.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_pause_tx
FILELIST = list.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run $(TOP) with $(SIM)"
	@echo "  clean  remove the build directory $(BUILD)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
